// ==== design/axi_rd_pkg.sv ====
package axi_rd_pkg;

    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int ID_WIDTH    = 4;
    localparam int ROM_WORDS   = 16;
    localparam int TRK_DEPTH   = 4;

    localparam int NUM_SLAVES  = 4;
    localparam int SLV_SEL_W   = $clog2(NUM_SLAVES);
    localparam int TRK_PTR_W   = $clog2(TRK_DEPTH);
    localparam int WORD_IDX_W  = $clog2(ROM_WORDS);
    localparam int REGION_BITS = 4;                   // Top address bits that pick the target
    localparam int LAT_CNT_W   = 4;                   // Wide enough for slave latencies up to 16
    localparam int IMG_WORDS   = NUM_SLAVES * ROM_WORDS;

    localparam string ROM_IMAGE = "design/rom_image.hex";

    // Mapped regions share their encoding with the slave port index
    typedef enum logic [2:0] {
        REG_S0   = 3'd0,
        REG_S1   = 3'd1,
        REG_S3   = 3'd2,
        REG_S4   = 3'd3,
        REG_NONE = 3'd4
    } region_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } resp_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
    } ar_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        resp_e                 resp;
        logic [ID_WIDTH-1:0]   id;
    } r_beat_t;

endpackage

// ==== design/axi_ar_slice.sv ====
module axi_ar_slice import axi_rd_pkg::*; (
    input  logic    clk_i,
    input  logic    rst,
    input  logic    in_valid,
    output logic    in_ready,
    input  ar_req_t in_req,
    output logic    out_valid,
    input  logic    out_ready,
    output ar_req_t out_req
);

    logic    main_valid;
    ar_req_t main_req;
    logic    skid_valid;
    ar_req_t skid_req;
    logic    main_free;
    logic    ready_q;

    assign main_free = !main_valid || out_ready;  // Main register empties this cycle
    assign in_ready  = ready_q;                   // Straight from a flop
    assign out_valid = main_valid;
    assign out_req   = main_req;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else if (main_free) begin
            ready_q <= 1'b1;                       // Skid entry is empty after this edge
            if (skid_valid) begin
                main_valid <= 1'b1;                // Drain the parked request first
                skid_valid <= 1'b0;
            end else begin
                main_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;                    // Output stalled so park the new one
            ready_q    <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (main_free) begin
            if (skid_valid) begin
                main_req <= skid_req;
            end else if (in_valid) begin
                main_req <= in_req;
            end
        end else if (in_valid && in_ready) begin
            skid_req <= in_req;
        end
    end

endmodule

// ==== design/axi_slave_mux_ar.sv ====
module axi_slave_mux_ar import axi_rd_pkg::*; (
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  ar_req_t               ar_req,
    output logic [NUM_SLAVES-1:0] s_ar_valid,
    input  logic [NUM_SLAVES-1:0] s_ar_ready,
    input  logic                  trk_space,
    output logic                  ar_fire,
    output region_e               ar_region
);

    logic [SLV_SEL_W-1:0] slv_sel;

    always_comb begin
        case (ar_req.addr[ADDR_WIDTH-1 -: REGION_BITS])
            4'h0: begin
                ar_region = REG_S0;
            end
            4'h1: begin
                ar_region = REG_S1;
            end
            4'h3: begin
                ar_region = REG_S3;
            end
            4'h4: begin
                ar_region = REG_S4;
            end
            default: begin
                ar_region = REG_NONE;
            end
        endcase
    end

    assign slv_sel = SLV_SEL_W'(ar_region);

    // A full tracker blocks every request, mapped or not
    always_comb begin
        s_ar_valid = '0;
        if (ar_region == REG_NONE) begin
            ar_ready = trk_space;  // Tracker answers these itself
        end else begin
            s_ar_valid[slv_sel] = ar_valid && trk_space;
            ar_ready            = s_ar_ready[slv_sel] && trk_space;
        end
    end

    assign ar_fire = ar_valid && ar_ready;

endmodule

// ==== design/axi_rom_slave.sv ====
module axi_rom_slave import axi_rd_pkg::*; #(
    parameter int SLOT    = 0,
    parameter int LATENCY = 1
) (
    input  logic    clk_i,
    input  logic    rst,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  ar_req_t ar_req,
    output logic    r_valid,
    input  logic    r_ready,
    output r_beat_t r_beat
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_e;

    state_e                 state;
    logic [LAT_CNT_W-1:0]   cnt;
    logic [WORD_IDX_W-1:0]  word_idx;
    logic [ID_WIDTH-1:0]    id_q;
    logic [DATA_WIDTH-1:0]  data_q;
    logic [DATA_WIDTH-1:0]  rom [ROM_WORDS];

    initial begin : load_rom
        logic [DATA_WIDTH-1:0] image [IMG_WORDS];
        $readmemh(ROM_IMAGE, image);
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = image[SLOT * ROM_WORDS + i];
        end
    end

    assign ar_ready = (state == ST_IDLE);
    assign r_valid  = (state == ST_RESP);
    assign r_beat   = '{data: data_q, resp: RESP_OKAY, id: id_q};

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_valid) begin
                        state <= ST_WAIT;
                        cnt   <= LAT_CNT_W'(LATENCY - 1);
                    end
                end
                ST_WAIT: begin
                    if (cnt == '0) begin
                        state <= ST_RESP;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_RESP: begin
                    if (r_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == ST_IDLE && ar_valid) begin
            word_idx <= ar_req.addr[WORD_IDX_W+1:2];  // Word aligned within the slave
            id_q     <= ar_req.id;
        end
        if (state == ST_WAIT && cnt == '0) begin
            data_q <= rom[word_idx];
        end
    end

endmodule

// ==== design/axi_read_tracker.sv ====
module axi_read_tracker import axi_rd_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst,
    input  logic                           ar_fire,
    input  region_e                        ar_region,
    input  logic [ID_WIDTH-1:0]            ar_id,
    output logic                           trk_space,
    input  logic [NUM_SLAVES-1:0]          s_r_valid,
    input  r_beat_t [NUM_SLAVES-1:0]       s_r_beat,
    output logic [NUM_SLAVES-1:0]          s_r_ready,
    output logic                           r_valid,
    input  logic                           r_ready,
    output r_beat_t                        r_beat
);

    typedef struct packed {
        region_e             region;
        logic [ID_WIDTH-1:0] id;
    } trk_entry_t;

    trk_entry_t             table_q [TRK_DEPTH];
    logic [TRK_PTR_W-1:0]   wr_ptr;
    logic [TRK_PTR_W-1:0]   rd_ptr;
    logic [TRK_PTR_W:0]     count;
    trk_entry_t             head;
    logic                   head_valid;
    logic                   head_none;
    logic [SLV_SEL_W-1:0]   head_sel;
    logic                   err_valid;
    logic                   r_fire;

    assign head       = table_q[rd_ptr];
    assign head_valid = (count != '0);
    assign head_none  = (head.region == REG_NONE);
    assign head_sel   = SLV_SEL_W'(head.region);
    assign trk_space  = (count != (TRK_PTR_W + 1)'(TRK_DEPTH));
    assign r_fire     = r_valid && r_ready;

    // Only the slave at the head of the table may hand over its beat
    always_comb begin
        s_r_ready = '0;
        if (head_valid && head_none) begin
            r_valid = err_valid;
            r_beat  = '{data: '0, resp: RESP_DECERR, id: head.id};
        end else if (head_valid) begin
            r_valid             = s_r_valid[head_sel];
            r_beat              = s_r_beat[head_sel];
            s_r_ready[head_sel] = r_ready;
        end else begin
            r_valid = 1'b0;
            r_beat  = s_r_beat[head_sel];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            err_valid <= 1'b0;
        end else begin
            if (ar_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (r_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (ar_fire && !r_fire) begin
                count <= count + 1'b1;
            end else if (r_fire && !ar_fire) begin
                count <= count - 1'b1;
            end
            // Error beat shows up one cycle after an unmapped entry reaches the head
            if (r_fire) begin
                err_valid <= 1'b0;
            end else begin
                err_valid <= head_valid && head_none;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            table_q[wr_ptr] <= '{region: ar_region, id: ar_id};
        end
    end

endmodule

// ==== design/axi_rd_subsys.sv ====
module axi_rd_subsys import axi_rd_pkg::*; (
    input  logic    clk_i,
    input  logic    rst,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  ar_req_t ar_req,
    output logic    r_valid,
    input  logic    r_ready,
    output r_beat_t r_beat
);

    logic                       slc_valid;
    logic                       slc_ready;
    ar_req_t                    slc_req;
    logic [NUM_SLAVES-1:0]      s_ar_valid;
    logic [NUM_SLAVES-1:0]      s_ar_ready;
    logic [NUM_SLAVES-1:0]      s_r_valid;
    logic [NUM_SLAVES-1:0]      s_r_ready;
    r_beat_t [NUM_SLAVES-1:0]   s_r_beat;
    logic                       ar_fire;
    region_e                    ar_region;
    logic                       trk_space;

    axi_ar_slice i_slice (
        .clk_i     (clk_i),
        .rst       (rst),
        .in_valid  (ar_valid),
        .in_ready  (ar_ready),
        .in_req    (ar_req),
        .out_valid (slc_valid),
        .out_ready (slc_ready),
        .out_req   (slc_req)
    );

    axi_slave_mux_ar i_mux (
        .ar_valid   (slc_valid),
        .ar_ready   (slc_ready),
        .ar_req     (slc_req),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .trk_space  (trk_space),
        .ar_fire    (ar_fire),
        .ar_region  (ar_region)
    );

    // Slots 0 to 3 serve regions 0, 1, 3 and 4, each one cycle slower than the last
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
        axi_rom_slave #(
            .SLOT    (i),
            .LATENCY (i + 1)
        ) i_rom (
            .clk_i    (clk_i),
            .rst      (rst),
            .ar_valid (s_ar_valid[i]),
            .ar_ready (s_ar_ready[i]),
            .ar_req   (slc_req),
            .r_valid  (s_r_valid[i]),
            .r_ready  (s_r_ready[i]),
            .r_beat   (s_r_beat[i])
        );
    end

    axi_read_tracker i_tracker (
        .clk_i     (clk_i),
        .rst       (rst),
        .ar_fire   (ar_fire),
        .ar_region (ar_region),
        .ar_id     (slc_req.id),
        .trk_space (trk_space),
        .s_r_valid (s_r_valid),
        .s_r_beat  (s_r_beat),
        .s_r_ready (s_r_ready),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_beat    (r_beat)
    );

endmodule

// ==== dv/axi_rd_tb.sv ====
module axi_rd_tb import axi_rd_pkg::*; ();

    logic                  clk_i;
    logic                  rst;
    logic                  ar_valid;
    logic                  ar_ready;
    ar_req_t               ar_req;
    logic                  r_valid;
    logic                  r_ready;
    r_beat_t               r_beat;

    logic [DATA_WIDTH-1:0] image [IMG_WORDS];
    r_beat_t               exp_q [$];
    r_beat_t               exp_beat;
    r_beat_t               held_beat;
    logic                  held_valid;
    logic                  rdy_random;
    logic [31:0]           stim_state;
    logic [31:0]           rdy_state;
    int                    errors;
    int                    checks;
    int                    wait_limit = 200;
    logic                  stuck;

    axi_rd_subsys i_dut (
        .clk_i    (clk_i),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_req   (ar_req),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_beat   (r_beat)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    function automatic r_beat_t expected_beat(input ar_req_t req);
        logic [1:0] slot;
        logic       mapped;
        mapped = 1'b1;
        slot   = 2'd0;
        case (req.addr[15:12])
            4'h0: slot = 2'd0;
            4'h1: slot = 2'd1;
            4'h3: slot = 2'd2;
            4'h4: slot = 2'd3;
            default: mapped = 1'b0;
        endcase
        if (!mapped) begin
            return '{data: '0, resp: RESP_DECERR, id: req.id};
        end
        return '{data: image[{slot, req.addr[5:2]}], resp: RESP_OKAY, id: req.id};
    endfunction

    task automatic send_read(input logic [ADDR_WIDTH-1:0] addr, input logic [ID_WIDTH-1:0] id);
        int waited;
        if (stuck) begin
            return;
        end
        waited   = 0;
        ar_valid = 1'b1;
        ar_req   = '{addr: addr, id: id};
        @(negedge clk_i);
        while (!ar_ready && !stuck) begin
            waited++;
            if (waited > wait_limit) begin
                $display("Timeout at %0t: ar_ready stayed low for a read to %h", $time, addr);
                errors++;
                stuck = 1'b1;
            end
            @(negedge clk_i);
        end
        if (!stuck) begin
            exp_q.push_back(expected_beat(ar_req));  // Accepted on the coming edge
        end
        @(posedge clk_i);
        #2;
        ar_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !stuck) begin
            @(posedge clk_i);
            #2;
            waited++;
            if (waited > wait_limit) begin
                $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
                errors++;
                stuck = 1'b1;
            end
        end
    endtask

    // Outputs are sampled mid cycle, well away from the edges where inputs move
    always @(negedge clk_i) begin
        if (!rst) begin
            if (held_valid) begin
                check("r_valid held", 64'(1'b1), 64'(r_valid));
                check("r_beat held", 64'(held_beat), 64'(r_beat));
            end
            if (r_valid && r_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: a response arrived with no read outstanding", $time);
                    errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check("r_beat", 64'(exp_beat), 64'(r_beat));
                end
            end
            held_valid = r_valid && !r_ready;
            held_beat  = r_beat;
        end
    end

    always @(posedge clk_i) begin
        #2;
        if (rdy_random) begin
            rdy_state = xorshift(rdy_state);
            r_ready   = rdy_state[0] | rdy_state[1];  // Ready about three cycles in four
        end else begin
            r_ready = 1'b1;
        end
    end

    task automatic reset_and_idle();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_i);
            check("ar_ready in reset", 64'(1'b0), 64'(ar_ready));
            check("r_valid in reset", 64'(1'b0), 64'(r_valid));
            check("s_ar_valid in reset", 64'(0), 64'(i_dut.s_ar_valid));
        end
        @(posedge clk_i);
        #2;
        rst = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_i);
            check("r_valid idle", 64'(1'b0), 64'(r_valid));
        end
        @(posedge clk_i);
        #2;
    endtask

    task automatic mapped_reads();
        logic [15:0] regions;
        regions = 16'h4310;
        for (int r = 0; r < 4; r++) begin
            for (int w = 0; w < 16; w += 5) begin
                stim_state = xorshift(stim_state);
                send_read({regions[3:0], stim_state[5:0], 4'(w), 2'b00}, stim_state[11:8]);
                wait_drain();
            end
            regions = regions >> 4;
        end
    endtask

    task automatic unmapped_reads();
        for (int t = 2; t < 16; t++) begin
            if (t != 3 && t != 4) begin
                stim_state = xorshift(stim_state);
                send_read({4'(t), stim_state[9:0], 2'b00}, stim_state[15:12]);
                wait_drain();
            end
        end
        send_read(16'h1014, 4'hA);  // Port must still serve mapped reads
        wait_drain();
    endtask

    task automatic mixed_stream(input int count, input logic random_ready);
        logic [3:0] top;
        @(negedge clk_i);
        rdy_random = random_ready;
        @(posedge clk_i);
        #2;
        for (int i = 0; i < count; i++) begin
            stim_state = xorshift(stim_state);
            case (stim_state[2:0])
                3'd0, 3'd5: top = 4'h0;
                3'd1: top = 4'h1;
                3'd2, 3'd6: top = 4'h3;
                3'd3: top = 4'h4;
                default: top = stim_state[7:4];  // Mostly unmapped
            endcase
            send_read({top, stim_state[13:8], stim_state[19:16], 2'b00}, stim_state[23:20]);
        end
        wait_drain();
        @(negedge clk_i);
        rdy_random = 1'b0;
        @(posedge clk_i);
        #2;
    endtask

    initial begin
        clk_i      = 1'b0;
        rst        = 1'b1;
        ar_valid   = 1'b0;
        ar_req     = '0;
        r_ready    = 1'b0;
        rdy_random = 1'b0;
        held_valid = 1'b0;
        stim_state = 32'd80;
        rdy_state  = 32'd80;
        errors     = 0;
        checks     = 0;
        stuck      = 1'b0;
        $readmemh(ROM_IMAGE, image);
        reset_and_idle();
        mapped_reads();
        unmapped_reads();
        mixed_stream(12, 1'b0);
        mixed_stream(40, 1'b1);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== design/rom_image.hex ====
// Each line is one 32-bit word and each slave owns 16 lines in slot order
00A5003C
01A5013C
02A5023C
03A5033C
04A5043C
05A5053C
06A5063C
07A5073C
08A5083C
09A5093C
0AA50A3C
0BA50B3C
0CA50C3C
0DA50D3C
0EA50E3C
0FA50F3C
10A5103C
11A5113C
12A5123C
13A5133C
14A5143C
15A5153C
16A5163C
17A5173C
18A5183C
19A5193C
1AA51A3C
1BA51B3C
1CA51C3C
1DA51D3C
1EA51E3C
1FA51F3C
20A5203C
21A5213C
22A5223C
23A5233C
24A5243C
25A5253C
26A5263C
27A5273C
28A5283C
29A5293C
2AA52A3C
2BA52B3C
2CA52C3C
2DA52D3C
2EA52E3C
2FA52F3C
30A5303C
31A5313C
32A5323C
33A5333C
34A5343C
35A5353C
36A5363C
37A5373C
38A5383C
39A5393C
3AA53A3C
3BA53B3C
3CA53C3C
3DA53D3C
3EA53E3C
3FA53F3C

// ==== all.f ====
design/axi_rd_pkg.sv
design/axi_ar_slice.sv
design/axi_slave_mux_ar.sv
design/axi_rom_slave.sv
design/axi_read_tracker.sv
design/axi_rd_subsys.sv
dv/axi_rd_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module axi_rd_tb -f all.f -o axi_rd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/axi_rd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
exit 1
